//--- glb_core.sv
`timescale 1ns/1ps

module glb_core (
    input  logic                               clk,
    input  logic                               reset,

    // processor port
    input  glb_pkg::proc_rq_packet_t           rq_local,
    output glb_pkg::proc_rs_packet_t           rs_local,

    // store dma settings
    input  logic [glb_pkg::BANK_ADDR_WIDTH-1:0] st_start,
    input  logic [glb_pkg::BANK_ADDR_WIDTH:0]   st_len,
    input  logic                               st_go,

    // tile stream in, valid only
    input  logic [glb_pkg::DATA_WIDTH-1:0]      stream_data,
    input  logic                               stream_valid,

    output logic                               st_done
);

    import glb_pkg::*;

    logic [DATA_WIDTH-1:0]      mem [2**BANK_ADDR_WIDTH];

    // store dma state
    logic                       st_running;
    logic [BANK_ADDR_WIDTH-1:0] st_addr;
    logic [BANK_ADDR_WIDTH:0]   st_remain;
    logic                       st_accept;

    // registered read response
    logic                       rd_req;
    logic                       rd_valid;
    logic [ADDR_WIDTH-1:0]      rd_addr;
    logic [DATA_WIDTH-1:0]      rd_data;

    // words while idle are dropped
    assign st_accept = st_running && stream_valid;
    assign rd_req    = rq_local.valid && !rq_local.wr_en;

    // bank writes
    always_ff @(posedge clk) begin
        if (rq_local.valid && rq_local.wr_en) begin
            mem[rq_local.addr] <= rq_local.wr_data;
        end
        // dma comes last, wins a clash on the same word
        if (st_accept) begin
            mem[st_addr] <= stream_data;
        end
    end

    // dma address and count
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_running <= 1'b0;
            st_addr    <= '0;
            st_remain  <= '0;
            st_done    <= 1'b0;
        end else begin
            st_done <= 1'b0;
            if (st_go) begin
                st_addr    <= st_start;
                st_remain  <= st_len;
                // zero length never starts
                st_running <= (st_len != '0);
            end else if (st_accept) begin
                st_addr   <= st_addr + 1'b1;
                st_remain <= st_remain - 1'b1;
                // last word, single cycle done
                if (st_remain == (BANK_ADDR_WIDTH+1)'(1)) begin
                    st_running <= 1'b0;
                    st_done    <= 1'b1;
                end
            end
        end
    end

    // read valid
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_req;
        end
    end

    // read payload, address kept for the response
    always_ff @(posedge clk) begin
        if (rd_req) begin
            rd_addr <= {rq_local.tile, rq_local.addr};
            rd_data <= mem[rq_local.addr];
        end
    end

    always_comb begin
        rs_local.valid   = rd_valid;
        rs_local.addr    = rd_addr;
        rs_local.rd_data = rd_data;
    end

endmodule

//--- glb_pkg.sv
package glb_pkg;

    // tile select bits at the top of a processor address
    localparam int TILE_ID_WIDTH = 2;
    // word address inside one bank, 256 words
    localparam int BANK_ADDR_WIDTH = 8;
    // full processor address, tile field plus word address
    localparam int ADDR_WIDTH = TILE_ID_WIDTH + BANK_ADDR_WIDTH;
    // memory word and stream word
    localparam int DATA_WIDTH = 16;
    // config register address bits
    localparam int CFG_REG_WIDTH = 2;

    // store dma config registers
    localparam logic [CFG_REG_WIDTH-1:0] CFG_ST_START = 2'd0;
    localparam logic [CFG_REG_WIDTH-1:0] CFG_ST_LEN = 2'd1;
    // write of any data starts the dma
    localparam logic [CFG_REG_WIDTH-1:0] CFG_ST_ON = 2'd2;

    // processor request, travels west to east
    typedef struct packed {
        logic                       valid;
        logic                       wr_en;
        logic [TILE_ID_WIDTH-1:0]   tile;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      wr_data;
    } proc_rq_packet_t;

    // read response, carries the whole request address back
    typedef struct packed {
        logic                  valid;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] rd_data;
    } proc_rs_packet_t;

    // config register write
    typedef struct packed {
        logic                     valid;
        logic [TILE_ID_WIDTH-1:0] tile;
        logic [CFG_REG_WIDTH-1:0] reg_addr;
        logic [DATA_WIDTH-1:0]    data;
    } cfg_packet_t;

endpackage

//--- glb_tile.sv
`timescale 1ns/1ps

module glb_tile #(
    parameter int TILE_ID   = 0,
    parameter int NUM_TILES = 4
) (
    input  logic                          clk,
    input  logic                          reset,

    // processor request chain
    input  glb_pkg::proc_rq_packet_t      rq_wsti,
    output glb_pkg::proc_rq_packet_t      rq_esto,

    // processor response chain
    input  glb_pkg::proc_rs_packet_t      rs_wsti,
    output glb_pkg::proc_rs_packet_t      rs_esto,

    // config chain
    input  glb_pkg::cfg_packet_t          cfg_wsti,
    output glb_pkg::cfg_packet_t          cfg_esto,

    // interrupt vector, one bit per tile
    input  logic [NUM_TILES-1:0]          interrupt_wsti,
    output logic [NUM_TILES-1:0]          interrupt_esto,

    // tile stream in
    input  logic [glb_pkg::DATA_WIDTH-1:0] stream_data,
    input  logic                          stream_valid
);

    import glb_pkg::*;

    // router to core
    proc_rq_packet_t            rq_local;
    // core to router
    proc_rs_packet_t            rs_local;

    // cfg to core
    logic [BANK_ADDR_WIDTH-1:0] st_start;
    logic [BANK_ADDR_WIDTH:0]   st_len;
    logic                       st_go;
    logic                       st_done;

    logic [NUM_TILES-1:0]       interrupt_next;

    glb_tile_cfg #(
        .TILE_ID(TILE_ID)
    ) glb_tile_cfg (
        .clk      (clk),
        .reset    (reset),
        .cfg_wsti (cfg_wsti),
        .cfg_esto (cfg_esto),
        .st_start (st_start),
        .st_len   (st_len),
        .st_go    (st_go)
    );

    glb_tile_proc_router #(
        .TILE_ID(TILE_ID)
    ) glb_tile_proc_router (
        .clk      (clk),
        .reset    (reset),
        .rq_wsti  (rq_wsti),
        .rq_esto  (rq_esto),
        .rs_wsti  (rs_wsti),
        .rs_esto  (rs_esto),
        .rq_local (rq_local),
        .rs_local (rs_local)
    );

    glb_core glb_core (
        .clk          (clk),
        .reset        (reset),
        .rq_local     (rq_local),
        .rs_local     (rs_local),
        .st_start     (st_start),
        .st_len       (st_len),
        .st_go        (st_go),
        .stream_data  (stream_data),
        .stream_valid (stream_valid),
        .st_done      (st_done)
    );

    // own bit comes from this tile's dma
    always_comb begin
        interrupt_next          = interrupt_wsti;
        interrupt_next[TILE_ID] = st_done;
    end

    // one register per hop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            interrupt_esto <= '0;
        end else begin
            interrupt_esto <= interrupt_next;
        end
    end

endmodule

//--- glb_tile_cfg.sv
`timescale 1ns/1ps

module glb_tile_cfg #(
    parameter int TILE_ID = 0
) (
    input  logic                               clk,
    input  logic                               reset,

    // config chain
    input  glb_pkg::cfg_packet_t               cfg_wsti,
    output glb_pkg::cfg_packet_t               cfg_esto,

    // store dma settings to the core
    output logic [glb_pkg::BANK_ADDR_WIDTH-1:0] st_start,
    output logic [glb_pkg::BANK_ADDR_WIDTH:0]   st_len,
    output logic                               st_go
);

    import glb_pkg::*;

    logic cfg_hit;

    // packet addressed to this tile
    assign cfg_hit = cfg_wsti.valid && (cfg_wsti.tile == TILE_ID_WIDTH'(TILE_ID));

    // every packet goes east unchanged, one cycle per hop
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_esto <= '0;
        end else begin
            cfg_esto <= cfg_wsti;
        end
    end

    // local register decode
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            st_start <= '0;
            st_len   <= '0;
            st_go    <= 1'b0;
        end else begin
            // start command lasts one cycle only
            st_go <= cfg_hit && (cfg_wsti.reg_addr == CFG_ST_ON);
            if (cfg_hit) begin
                case (cfg_wsti.reg_addr)
                    CFG_ST_START: begin
                        st_start <= cfg_wsti.data[BANK_ADDR_WIDTH-1:0];
                    end
                    CFG_ST_LEN: begin
                        // one extra bit so a full bank fits
                        st_len <= cfg_wsti.data[BANK_ADDR_WIDTH:0];
                    end
                    default: begin
                        // start command handled above
                    end
                endcase
            end
        end
    end

endmodule

//--- glb_tile_proc_router.sv
`timescale 1ns/1ps

module glb_tile_proc_router #(
    parameter int TILE_ID = 0
) (
    input  logic                     clk,
    input  logic                     reset,

    // request chain
    input  glb_pkg::proc_rq_packet_t rq_wsti,
    output glb_pkg::proc_rq_packet_t rq_esto,

    // response chain
    input  glb_pkg::proc_rs_packet_t rs_wsti,
    output glb_pkg::proc_rs_packet_t rs_esto,

    // core side
    output glb_pkg::proc_rq_packet_t rq_local,
    input  glb_pkg::proc_rs_packet_t rs_local
);

    import glb_pkg::*;

    logic rq_hit;

    // request for this tile
    assign rq_hit = rq_wsti.valid && (rq_wsti.tile == TILE_ID_WIDTH'(TILE_ID));

    // core sees the request only on a tile match
    always_comb begin
        rq_local       = rq_wsti;
        rq_local.valid = rq_hit;
    end

    // request forward stage
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rq_esto <= '0;
        end else begin
            rq_esto <= rq_wsti;
            // served here, so later tiles must not serve it again
            if (rq_hit) begin
                rq_esto.valid <= 1'b0;
            end
        end
    end

    // response forward stage
    // a local and a through response never meet in the same cycle,
    // both would have to come from one request
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            rs_esto <= '0;
        end else if (rs_local.valid) begin
            rs_esto <= rs_local;
        end else begin
            rs_esto <= rs_wsti;
        end
    end

endmodule

//--- glb_top.sv
`timescale 1ns/1ps

module glb_top #(
    parameter int NUM_TILES = 4
) (
    input  logic                                          clk,
    input  logic                                          reset,

    // west inputs
    input  glb_pkg::proc_rq_packet_t                      rq_in,
    input  glb_pkg::cfg_packet_t                          cfg_in,

    // east outputs
    output glb_pkg::proc_rs_packet_t                      rs_out,
    output logic [NUM_TILES-1:0]                          interrupt,

    // one stream per tile
    input  logic [NUM_TILES-1:0][glb_pkg::DATA_WIDTH-1:0] stream_data,
    input  logic [NUM_TILES-1:0]                          stream_valid
);

    import glb_pkg::*;

    // entry 0 is the west end, entry i+1 is tile i's output
    proc_rq_packet_t      rq_chain  [NUM_TILES+1];
    proc_rs_packet_t      rs_chain  [NUM_TILES+1];
    cfg_packet_t          cfg_chain [NUM_TILES+1];
    logic [NUM_TILES-1:0] int_chain [NUM_TILES+1];

    assign rq_chain[0]  = rq_in;
    assign cfg_chain[0] = cfg_in;
    // nothing enters the response or interrupt chains from the west
    assign rs_chain[0]  = '0;
    assign int_chain[0] = '0;

    assign rs_out    = rs_chain[NUM_TILES];
    assign interrupt = int_chain[NUM_TILES];

    for (genvar i = 0; i < NUM_TILES; i++) begin : g_tile
        glb_tile #(
            .TILE_ID   (i),
            .NUM_TILES (NUM_TILES)
        ) glb_tile (
            .clk            (clk),
            .reset          (reset),
            .rq_wsti        (rq_chain[i]),
            .rq_esto        (rq_chain[i+1]),
            .rs_wsti        (rs_chain[i]),
            .rs_esto        (rs_chain[i+1]),
            .cfg_wsti       (cfg_chain[i]),
            .cfg_esto       (cfg_chain[i+1]),
            .interrupt_wsti (int_chain[i]),
            .interrupt_esto (int_chain[i+1]),
            .stream_data    (stream_data[i]),
            .stream_valid   (stream_valid[i])
        );
    end

endmodule

//--- run.sh
#!/bin/sh
# build with verilator, run, then look for the pass line in the log
verilator --binary --timing -Wno-fatal --top-module tb_glb_top -f sim.f > build.log 2>&1 \
    && ./obj_dir/Vtb_glb_top > sim.log 2>&1 \
    && grep -q "^sim passed$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see build.log and sim.log"; exit 1; }

//--- sim.f
glb_pkg.sv
glb_tile_cfg.sv
glb_tile_proc_router.sv
glb_core.sv
glb_tile.sv
glb_top.sv
tb_glb_top.sv

//--- tb_glb_top.sv
`timescale 1ns/1ps

module tb_glb_top;

    import glb_pkg::*;

    localparam int NUM_TILES = 4;
    // size of the per-cycle interrupt expectation
    localparam int MAX_CYC = 1024;

    // row kinds, idle is zero so a cleared row does nothing
    localparam logic [2:0] K_IDLE = 3'd0;
    localparam logic [2:0] K_WR   = 3'd1;
    localparam logic [2:0] K_RD   = 3'd2;
    localparam logic [2:0] K_CFG  = 3'd3;
    localparam logic [2:0] K_STR  = 3'd4;

    // one table row per cycle
    typedef struct packed {
        logic [2:0]                 kind;
        logic [TILE_ID_WIDTH-1:0]   tile;
        logic [BANK_ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0]      data;
    } row_t;

    // expected read response and its cycle
    typedef struct packed {
        int                    due;
        logic [ADDR_WIDTH-1:0] addr;
        logic [DATA_WIDTH-1:0] data;
    } exp_rs_t;

    logic                                 clk;
    logic                                 reset;
    proc_rq_packet_t                      rq_in;
    cfg_packet_t                          cfg_in;
    proc_rs_packet_t                      rs_out;
    logic [NUM_TILES-1:0]                 interrupt;
    logic [NUM_TILES-1:0][DATA_WIDTH-1:0] stream_data;
    logic [NUM_TILES-1:0]                 stream_valid;

    row_t    rows [$];
    exp_rs_t exp_q [$];

    // bank contents as the driven traffic leaves them
    logic [DATA_WIDTH-1:0]      mem_model [NUM_TILES][2**BANK_ADDR_WIDTH];
    logic [NUM_TILES-1:0]       exp_int [MAX_CYC];

    // store dma model per tile
    logic [BANK_ADDR_WIDTH-1:0] cfg_start [NUM_TILES];
    logic [BANK_ADDR_WIDTH:0]   cfg_len [NUM_TILES];
    logic [BANK_ADDR_WIDTH-1:0] dma_addr [NUM_TILES];
    int                         dma_left [NUM_TILES];
    int                         dma_run_at [NUM_TILES];
    int                         int_seen [NUM_TILES];
    int                         int_want [NUM_TILES];

    integer seed;
    int     errors;
    int     cyc;
    int     limit;
    int     last_due;
    int     max_len;

    glb_top #(
        .NUM_TILES (NUM_TILES)
    ) dut (
        .clk          (clk),
        .reset        (reset),
        .rq_in        (rq_in),
        .cfg_in       (cfg_in),
        .rs_out       (rs_out),
        .interrupt    (interrupt),
        .stream_data  (stream_data),
        .stream_valid (stream_valid)
    );

    initial clk = 1'b0;
    always #20 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("MISMATCH time=%0t signal=%s actual=%h expected=%h",
                     $time, name, actual, expected);
        end
    endtask

    // expands one table entry into per-cycle rows
    task automatic add_entry(input logic [2:0] kind, input int tile, input int addr,
                             input int data, input int len);
        row_t r;
        r.kind = kind;
        r.tile = TILE_ID_WIDTH'(tile);
        r.addr = BANK_ADDR_WIDTH'(addr);
        r.data = DATA_WIDTH'(data);
        if (kind == K_CFG) begin
            if (len > max_len) begin
                max_len = len;
            end
            // start address, length, then go
            r.addr = BANK_ADDR_WIDTH'(CFG_ST_START);
            r.data = DATA_WIDTH'(addr);
            rows.push_back(r);
            r.addr = BANK_ADDR_WIDTH'(CFG_ST_LEN);
            r.data = DATA_WIDTH'(len);
            rows.push_back(r);
            r.addr = BANK_ADDR_WIDTH'(CFG_ST_ON);
            r.data = '0;
            rows.push_back(r);
        end else if (kind == K_STR || kind == K_IDLE) begin
            repeat (len) rows.push_back(r);
        end else begin
            rows.push_back(r);
        end
    endtask

    task automatic build_table();
        int t;
        int i;
        // fill, data depends on tile and word
        for (t = 0; t < NUM_TILES; t++) begin
            add_entry(K_WR, t, 'h20, 'ha000 + t * 256 + 'h20, 0);
            add_entry(K_WR, t, 'h21, 'hb000 + t * 256 + 'h21, 0);
        end
        // tile 2 only, same word address
        add_entry(K_WR, 2, 'h20, 'h5a5a, 0);
        add_entry(K_WR, 2, 'h00, 'h1234, 0);
        add_entry(K_WR, 1, 'h44, 'h4444, 0);
        // back to back reads across tiles
        for (t = 0; t < NUM_TILES; t++) begin
            add_entry(K_RD, t, 'h20, 0, 0);
        end
        for (t = 0; t < NUM_TILES; t++) begin
            add_entry(K_RD, t, 'h21, 0, 0);
        end
        add_entry(K_IDLE, 0, 0, 0, 2);
        // dma idle, words dropped
        add_entry(K_STR, 2, 0, 0, 3);
        add_entry(K_STR, 1, 0, 0, 2);
        // two dmas, tile 3 ends later
        add_entry(K_CFG, 1, 'h40, 0, 4);
        add_entry(K_CFG, 3, 'h80, 0, 6);
        add_entry(K_IDLE, 0, 0, 0, 6);
        add_entry(K_STR, 3, 0, 0, 2);
        add_entry(K_STR, 1, 0, 0, 4);
        add_entry(K_STR, 3, 0, 0, 4);
        // past the length, dropped
        add_entry(K_STR, 1, 0, 0, 2);
        add_entry(K_IDLE, 0, 0, 0, 4);
        for (i = 0; i < 5; i++) begin
            add_entry(K_RD, 1, 'h40 + i, 0, 0);
        end
        for (i = 0; i < 6; i++) begin
            add_entry(K_RD, 3, 'h80 + i, 0, 0);
        end
        add_entry(K_RD, 2, 'h00, 0, 0);
        add_entry(K_RD, 2, 'h20, 0, 0);
    endtask

    // drives one row and updates the model
    task automatic apply_row(input row_t r);
        exp_rs_t               e;
        logic [DATA_WIDTH-1:0] word;
        int                    k;
        int                    due;
        k            = int'(r.tile);
        rq_in        = '0;
        cfg_in       = '0;
        stream_valid = '0;
        stream_data  = '0;
        case (r.kind)
            K_WR: begin
                rq_in.valid   = 1'b1;
                rq_in.wr_en   = 1'b1;
                rq_in.tile    = r.tile;
                rq_in.addr    = r.addr;
                rq_in.wr_data = r.data;
                mem_model[k][r.addr] = r.data;
            end
            K_RD: begin
                rq_in.valid = 1'b1;
                rq_in.tile  = r.tile;
                rq_in.addr  = r.addr;
                // same latency whatever tile serves it
                e.due  = cyc + NUM_TILES + 1;
                e.addr = {r.tile, r.addr};
                e.data = mem_model[k][r.addr];
                exp_q.push_back(e);
                if (e.due > last_due) begin
                    last_due = e.due;
                end
            end
            K_CFG: begin
                cfg_in.valid    = 1'b1;
                cfg_in.tile     = r.tile;
                cfg_in.reg_addr = r.addr[CFG_REG_WIDTH-1:0];
                cfg_in.data     = r.data;
                if (cfg_in.reg_addr == CFG_ST_START) begin
                    cfg_start[k] = r.data[BANK_ADDR_WIDTH-1:0];
                end else if (cfg_in.reg_addr == CFG_ST_LEN) begin
                    cfg_len[k] = r.data[BANK_ADDR_WIDTH:0];
                end else begin
                    // packet at tile k in cycle k, go pulse next, running after that
                    dma_run_at[k] = cyc + k + 2;
                    dma_addr[k]   = cfg_start[k];
                    dma_left[k]   = int'(cfg_len[k]);
                end
            end
            K_STR: begin
                word            = DATA_WIDTH'($random(seed));
                stream_valid[k] = 1'b1;
                stream_data[k]  = word;
                if (cyc >= dma_run_at[k] && dma_left[k] > 0) begin
                    mem_model[k][dma_addr[k]] = word;
                    dma_addr[k] = dma_addr[k] + 1'b1;
                    dma_left[k]--;
                    if (dma_left[k] == 0) begin
                        // done one cycle later, then N-k hops east
                        due = cyc + 1 + NUM_TILES - k;
                        exp_int[due][k] = 1'b1;
                        int_want[k]++;
                        if (due > last_due) begin
                            last_due = due;
                        end
                    end
                end
            end
            default: begin
                // idle cycle
            end
        endcase
    endtask

    task automatic check_outputs();
        exp_rs_t e;
        int      k;
        if (exp_q.size() > 0 && exp_q[0].due == cyc) begin
            e = exp_q.pop_front();
            check_value("rs_out.valid", rs_out.valid, 1'b1);
            check_value("rs_out.addr", rs_out.addr, e.addr);
            check_value("rs_out.rd_data", rs_out.rd_data, e.data);
        end else begin
            check_value("rs_out.valid", rs_out.valid, 1'b0);
        end
        check_value("interrupt", interrupt, exp_int[cyc]);
        for (k = 0; k < NUM_TILES; k++) begin
            if (interrupt[k]) begin
                int_seen[k]++;
            end
        end
    endtask

    initial begin
        row_t idle_row;
        idle_row     = '0;
        errors       = 0;
        cyc          = 0;
        last_due     = 0;
        max_len      = 0;
        seed         = 32'h4e3d_17ca;
        reset        = 1'b1;
        rq_in        = '0;
        cfg_in       = '0;
        stream_data  = '0;
        stream_valid = '0;
        for (int i = 0; i < MAX_CYC; i++) begin
            exp_int[i] = '0;
        end
        for (int k = 0; k < NUM_TILES; k++) begin
            cfg_start[k]  = '0;
            cfg_len[k]    = '0;
            dma_addr[k]   = '0;
            dma_left[k]   = 0;
            dma_run_at[k] = 0;
            int_seen[k]   = 0;
            int_want[k]   = 0;
        end
        build_table();
        limit = rows.size() + max_len + 4 * NUM_TILES + 50;
        repeat (16) @(posedge clk);
        #2;
        reset = 1'b0;
        // one row per cycle, then drain the pending responses
        while ((cyc < rows.size() || cyc <= last_due) && cyc < limit) begin
            check_outputs();
            if (cyc < rows.size()) begin
                apply_row(rows[cyc]);
            end else begin
                apply_row(idle_row);
            end
            @(posedge clk);
            #2;
            cyc++;
        end
        if (cyc < rows.size() || cyc <= last_due) begin
            errors++;
            $display("timeout: run stopped at %0d cycles with work still pending", limit);
        end
        for (int k = 0; k < NUM_TILES; k++) begin
            if (int_seen[k] != int_want[k]) begin
                errors++;
                $display("tile %0d raised its interrupt in %0d cycles, %0d pulses expected",
                         k, int_seen[k], int_want[k]);
            end
        end
        $display("errors: %0d, cycles run: %0d", errors, cyc);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
